// ==== filelist.f ====
design/host_bus_pkg.sv
design/host_map_pkg.sv
design/dma_evt_sync.sv
design/mem_access_monitor.sv
design/event_counter_bank.sv
design/cfg_lite_slave.sv
design/host_domain.sv
bench/tb_host_domain.sv

// ==== bench/tb_host_domain.sv ====
`timescale 1ns/1ps

module tb_host_domain;

  localparam logic [31:0] FillWord  = 32'hdeadf000;
  localparam int          WaitLimit = 50;

  logic        clk_i;
  logic        rst_n_i;
  logic        mem_req_valid_i;
  logic [63:0] mem_req_addr_i;
  logic        mem_req_we_i;
  logic        dma_pe_evt_valid_i;
  logic        dma_pe_evt_ack_o;
  logic [31:0] cfg_aw_addr_i;
  logic        cfg_aw_valid_i;
  logic        cfg_aw_ready_o;
  logic [31:0] cfg_w_data_i;
  logic        cfg_w_valid_i;
  logic        cfg_w_ready_o;
  logic [1:0]  cfg_b_resp_o;
  logic        cfg_b_valid_o;
  logic        cfg_b_ready_i;
  logic [31:0] cfg_ar_addr_i;
  logic        cfg_ar_valid_i;
  logic        cfg_ar_ready_o;
  logic [31:0] cfg_r_data_o;
  logic [1:0]  cfg_r_resp_o;
  logic        cfg_r_valid_o;
  logic        cfg_r_ready_i;
  logic        pmu_irq_o;

  logic [15:0] lfsr_q;
  int          model_cnt [5];
  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;

  host_domain i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  task automatic lite_write(input logic [31:0] addr, input logic [31:0] data);
    int n;
    cfg_aw_addr_i  = addr;
    cfg_w_data_i   = data;
    cfg_aw_valid_i = 1'b1;
    cfg_w_valid_i  = 1'b1;
    n = 0;
    while (!(cfg_aw_ready_o && cfg_w_ready_o) && n < WaitLimit) begin
      wait_cycles(1);
      n++;
    end
    if (n == WaitLimit) begin
      $display("Timed out waiting for AW/W ready on write to %h at %0t", addr, $time);
      err_cnt++;
    end
    wait_cycles(1);
    cfg_aw_valid_i = 1'b0;
    cfg_w_valid_i  = 1'b0;
    n = 0;
    while (!cfg_b_valid_o && n < WaitLimit) begin
      wait_cycles(1);
      n++;
    end
    if (n == WaitLimit) begin
      $display("Timed out waiting for the write response from %h at %0t", addr, $time);
      err_cnt++;
    end else if (cfg_b_resp_o !== 2'b00) begin
      $display("ERROR %0t: write to %h got response %0d", $time, addr, cfg_b_resp_o);
      err_cnt++;
    end
    wait_cycles(1);
  endtask

  task automatic lite_read(input logic [31:0] addr, output logic [31:0] data);
    int n;
    cfg_ar_addr_i  = addr;
    cfg_ar_valid_i = 1'b1;
    n = 0;
    while (!cfg_ar_ready_o && n < WaitLimit) begin
      wait_cycles(1);
      n++;
    end
    if (n == WaitLimit) begin
      $display("Timed out waiting for AR ready on read of %h at %0t", addr, $time);
      err_cnt++;
    end
    wait_cycles(1);
    cfg_ar_valid_i = 1'b0;
    n = 0;
    while (!cfg_r_valid_o && n < WaitLimit) begin
      wait_cycles(1);
      n++;
    end
    if (n == WaitLimit) begin
      $display("Timed out waiting for the read response from %h at %0t", addr, $time);
      err_cnt++;
    end else if (cfg_r_resp_o !== 2'b00) begin
      $display("ERROR %0t: read of %h got response %0d", $time, addr, cfg_r_resp_o);
      err_cnt++;
    end
    data = cfg_r_data_o;
    wait_cycles(1);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    lite_read(addr, got);
    if (got !== exp) begin
      $display("ERROR %0t: read of %h returned %h, expected %h", $time, addr, got, exp);
      err_cnt++;
    end
  endtask

  task automatic mem_strobe(input logic [63:0] addr, input logic we);
    mem_req_valid_i = 1'b1;
    mem_req_addr_i  = addr;
    mem_req_we_i    = we;
    wait_cycles(1);
    mem_req_valid_i = 1'b0;
  endtask

  task automatic dma_event();
    int n;
    dma_pe_evt_valid_i = 1'b1;
    n = 0;
    while (!dma_pe_evt_ack_o && n < WaitLimit) begin
      wait_cycles(1);
      n++;
    end
    if (n == WaitLimit) begin
      $display("Timed out waiting for the DMA ack to rise at %0t", $time);
      err_cnt++;
    end
    dma_pe_evt_valid_i = 1'b0;
    n = 0;
    while (dma_pe_evt_ack_o && n < WaitLimit) begin
      wait_cycles(1);
      n++;
    end
    if (n == WaitLimit) begin
      $display("Timed out waiting for the DMA ack to fall at %0t", $time);
      err_cnt++;
    end
  endtask

  task automatic close_test(input string name, input int err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("%s: passed", name);
    end else begin
      fail_cnt++;
      $display("%s: failed with %0d errors", name, err_cnt - err_start);
    end
  endtask

  task automatic check_reset_values();
    int e0;
    e0 = err_cnt;
    for (int k = 0; k < 5; k++) begin
      read_expect(4 * k, 32'h0);
    end
    read_expect(32'h20, 32'h0);
    read_expect(32'h24, 32'h0);
    if (pmu_irq_o !== 1'b0) begin
      $display("ERROR %0t: interrupt high after reset", $time);
      err_cnt++;
    end
    read_expect(32'h30, FillWord);
    close_test("reset values", e0);
  endtask

  task automatic count_random_strobes();
    int          e0;
    logic [31:0] sel;
    logic [31:0] we;
    logic [31:0] off;
    logic [63:0] addr;
    e0 = err_cnt;
    for (int i = 0; i < 40; i++) begin
      rand_bits(2, sel);
      rand_bits(1, we);
      rand_bits(31, off);
      // Two select bits pick debug, HyperRAM or one of two unmapped spaces
      case (sel[1:0])
        2'd0: addr = {33'h0, off[30:0]};
        2'd1: addr = {32'h0, 2'b10, off[29:0]};
        2'd2: addr = {32'h0, 2'b11, off[29:0]};
        default: addr = {32'h1, 1'b0, off[30:0]};
      endcase
      if (sel[1:0] < 2) begin
        model_cnt[sel[1:0] * 2 + we[0]]++;
      end
      mem_strobe(addr, we[0]);
    end
    wait_cycles(3);
    for (int k = 0; k < 5; k++) begin
      read_expect(4 * k, model_cnt[k]);
    end
    close_test("random strobes", e0);
  endtask

  task automatic clear_counter_by_write();
    int e0;
    e0 = err_cnt;
    mem_strobe(64'h0000_2000, 1'b0);
    model_cnt[0]++;
    wait_cycles(3);
    lite_write(32'h0, 32'hffff_ffff);
    model_cnt[0] = 0;
    read_expect(32'h0, 32'h0);
    mem_strobe(64'h0000_1000, 1'b0);
    model_cnt[0] = 1;
    wait_cycles(3);
    read_expect(32'h0, 32'h1);
    lite_write(32'h30, 32'hffff_ffff);
    for (int k = 0; k < 5; k++) begin
      read_expect(4 * k, model_cnt[k]);
    end
    read_expect(32'h20, 32'h0);
    read_expect(32'h24, 32'h0);
    close_test("counter clear", e0);
  endtask

  task automatic count_dma_events();
    int e0;
    e0 = err_cnt;
    dma_event();
    wait_cycles(2);
    read_expect(32'h10, 32'h1);
    dma_event();
    dma_event();
    wait_cycles(2);
    model_cnt[4] = 3;
    read_expect(32'h10, 32'h3);
    close_test("dma events", e0);
  endtask

  task automatic raise_threshold_irq();
    int e0;
    e0 = err_cnt;
    lite_write(32'h20, 32'h2);
    lite_write(32'h8, 32'h0);
    mem_strobe(64'h0000_0000_8000_0040, 1'b0);
    wait_cycles(3);
    read_expect(32'h24, 32'h0);
    mem_strobe(64'h0000_0000_8000_0080, 1'b0);
    model_cnt[2] = 2;
    wait_cycles(3);
    read_expect(32'h24, 32'h4);
    if (pmu_irq_o !== 1'b1) begin
      $display("ERROR %0t: interrupt not raised on threshold match", $time);
      err_cnt++;
    end
    lite_write(32'h24, 32'h4);
    read_expect(32'h24, 32'h0);
    if (pmu_irq_o !== 1'b0) begin
      $display("ERROR %0t: interrupt still high after status clear", $time);
      err_cnt++;
    end
    close_test("threshold interrupt", e0);
  endtask

  task automatic hold_under_backpressure();
    int e0;
    e0 = err_cnt;
    cfg_r_ready_i  = 1'b0;
    cfg_ar_addr_i  = 32'h8;
    cfg_ar_valid_i = 1'b1;
    wait_cycles(1);
    cfg_ar_valid_i = 1'b0;
    // A fresh capture would now show the fill word
    cfg_ar_addr_i  = 32'h30;
    for (int i = 0; i < 4; i++) begin
      if (cfg_r_valid_o !== 1'b1 || cfg_r_data_o !== model_cnt[2] ||
          cfg_ar_ready_o !== 1'b0) begin
        $display("ERROR %0t: read response not held, valid %b data %h ar_ready %b",
                 $time, cfg_r_valid_o, cfg_r_data_o, cfg_ar_ready_o);
        err_cnt++;
      end
      wait_cycles(1);
    end
    cfg_r_ready_i = 1'b1;
    wait_cycles(1);
    if (cfg_r_valid_o !== 1'b0 || cfg_ar_ready_o !== 1'b1) begin
      $display("ERROR %0t: read response not released", $time);
      err_cnt++;
    end
    cfg_b_ready_i  = 1'b0;
    cfg_aw_addr_i  = 32'h20;
    cfg_w_data_i   = 32'h5;
    cfg_aw_valid_i = 1'b1;
    cfg_w_valid_i  = 1'b1;
    wait_cycles(1);
    cfg_aw_valid_i = 1'b0;
    cfg_w_valid_i  = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (cfg_b_valid_o !== 1'b1 || cfg_b_resp_o !== 2'b00 ||
          cfg_aw_ready_o !== 1'b0 || cfg_w_ready_o !== 1'b0) begin
        $display("ERROR %0t: write response not held, valid %b aw_ready %b w_ready %b",
                 $time, cfg_b_valid_o, cfg_aw_ready_o, cfg_w_ready_o);
        err_cnt++;
      end
      wait_cycles(1);
    end
    cfg_b_ready_i = 1'b1;
    wait_cycles(1);
    if (cfg_b_valid_o !== 1'b0 || cfg_aw_ready_o !== 1'b1 || cfg_w_ready_o !== 1'b1) begin
      $display("ERROR %0t: write response not released", $time);
      err_cnt++;
    end
    read_expect(32'h20, 32'h5);
    close_test("back-pressure", e0);
  endtask

  initial begin
    rst_n_i            = 1'b0;
    mem_req_valid_i    = 1'b0;
    mem_req_addr_i     = '0;
    mem_req_we_i       = 1'b0;
    dma_pe_evt_valid_i = 1'b0;
    cfg_aw_addr_i      = '0;
    cfg_aw_valid_i     = 1'b0;
    cfg_w_data_i       = '0;
    cfg_w_valid_i      = 1'b0;
    cfg_b_ready_i      = 1'b1;
    cfg_ar_addr_i      = '0;
    cfg_ar_valid_i     = 1'b0;
    cfg_r_ready_i      = 1'b1;
    lfsr_q             = 16'd30;
    err_cnt            = 0;
    test_cnt           = 0;
    fail_cnt           = 0;
    for (int k = 0; k < 5; k++) begin
      model_cnt[k] = 0;
    end
    wait_cycles(5);
    rst_n_i = 1'b1;
    wait_cycles(1);
    check_reset_values();
    count_random_strobes();
    clear_counter_by_write();
    count_dma_events();
    raise_threshold_irq();
    hold_under_backpressure();
    $display("Tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== design/host_domain.sv ====
`timescale 1ns/1ps

module host_domain #(
  parameter int unsigned CounterWidth = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Memory request strobe
  input  logic                     mem_req_valid_i,
  input  host_bus_pkg::addr_t      mem_req_addr_i,
  input  logic                     mem_req_we_i,
  // Cluster DMA event
  input  logic                     dma_pe_evt_valid_i,
  output logic                     dma_pe_evt_ack_o,
  // AXI-Lite configuration
  input  host_bus_pkg::lite_addr_t cfg_aw_addr_i,
  input  logic                     cfg_aw_valid_i,
  output logic                     cfg_aw_ready_o,
  input  host_bus_pkg::lite_data_t cfg_w_data_i,
  input  logic                     cfg_w_valid_i,
  output logic                     cfg_w_ready_o,
  output host_bus_pkg::resp_t      cfg_b_resp_o,
  output logic                     cfg_b_valid_o,
  input  logic                     cfg_b_ready_i,
  input  host_bus_pkg::lite_addr_t cfg_ar_addr_i,
  input  logic                     cfg_ar_valid_i,
  output logic                     cfg_ar_ready_o,
  output host_bus_pkg::lite_data_t cfg_r_data_o,
  output host_bus_pkg::resp_t      cfg_r_resp_o,
  output logic                     cfg_r_valid_o,
  input  logic                     cfg_r_ready_i,
  output logic                     pmu_irq_o
);

  logic [3:0]               mem_evt;
  logic                     dma_evt;
  host_map_pkg::evt_vec_t   evt_vec;
  logic                     reg_wr;
  host_bus_pkg::lite_addr_t reg_waddr;
  host_bus_pkg::lite_data_t reg_wdata;
  host_bus_pkg::lite_addr_t reg_raddr;
  host_bus_pkg::lite_data_t reg_rdata;

  // DMA event sits above the four memory events
  assign evt_vec = {dma_evt, mem_evt};

  mem_access_monitor i_mem_access_monitor (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .mem_req_valid_i ( mem_req_valid_i ),
    .mem_req_addr_i  ( mem_req_addr_i  ),
    .mem_req_we_i    ( mem_req_we_i    ),
    .mem_evt_o       ( mem_evt         )
  );

  dma_evt_sync i_dma_evt_sync (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .valid_o ( dma_evt            )
  );

  event_counter_bank #(
    .CounterWidth ( CounterWidth )
  ) i_event_counter_bank (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .evt_i       ( evt_vec   ),
    .reg_wr_i    ( reg_wr    ),
    .reg_waddr_i ( reg_waddr ),
    .reg_wdata_i ( reg_wdata ),
    .reg_raddr_i ( reg_raddr ),
    .reg_rdata_o ( reg_rdata ),
    .irq_o       ( pmu_irq_o )
  );

  cfg_lite_slave i_cfg_lite_slave (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .cfg_aw_addr_i  ( cfg_aw_addr_i  ),
    .cfg_aw_valid_i ( cfg_aw_valid_i ),
    .cfg_aw_ready_o ( cfg_aw_ready_o ),
    .cfg_w_data_i   ( cfg_w_data_i   ),
    .cfg_w_valid_i  ( cfg_w_valid_i  ),
    .cfg_w_ready_o  ( cfg_w_ready_o  ),
    .cfg_b_resp_o   ( cfg_b_resp_o   ),
    .cfg_b_valid_o  ( cfg_b_valid_o  ),
    .cfg_b_ready_i  ( cfg_b_ready_i  ),
    .cfg_ar_addr_i  ( cfg_ar_addr_i  ),
    .cfg_ar_valid_i ( cfg_ar_valid_i ),
    .cfg_ar_ready_o ( cfg_ar_ready_o ),
    .cfg_r_data_o   ( cfg_r_data_o   ),
    .cfg_r_resp_o   ( cfg_r_resp_o   ),
    .cfg_r_valid_o  ( cfg_r_valid_o  ),
    .cfg_r_ready_i  ( cfg_r_ready_i  ),
    .reg_wr_o       ( reg_wr         ),
    .reg_waddr_o    ( reg_waddr      ),
    .reg_wdata_o    ( reg_wdata      ),
    .reg_raddr_o    ( reg_raddr      ),
    .reg_rdata_i    ( reg_rdata      )
  );

endmodule

// ==== design/cfg_lite_slave.sv ====
`timescale 1ns/1ps

module cfg_lite_slave (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // AW
  input  host_bus_pkg::lite_addr_t cfg_aw_addr_i,
  input  logic                     cfg_aw_valid_i,
  output logic                     cfg_aw_ready_o,
  // W
  input  host_bus_pkg::lite_data_t cfg_w_data_i,
  input  logic                     cfg_w_valid_i,
  output logic                     cfg_w_ready_o,
  // B
  output host_bus_pkg::resp_t      cfg_b_resp_o,
  output logic                     cfg_b_valid_o,
  input  logic                     cfg_b_ready_i,
  // AR
  input  host_bus_pkg::lite_addr_t cfg_ar_addr_i,
  input  logic                     cfg_ar_valid_i,
  output logic                     cfg_ar_ready_o,
  // R
  output host_bus_pkg::lite_data_t cfg_r_data_o,
  output host_bus_pkg::resp_t      cfg_r_resp_o,
  output logic                     cfg_r_valid_o,
  input  logic                     cfg_r_ready_i,
  // Register port
  output logic                     reg_wr_o,
  output host_bus_pkg::lite_addr_t reg_waddr_o,
  output host_bus_pkg::lite_data_t reg_wdata_o,
  output host_bus_pkg::lite_addr_t reg_raddr_o,
  input  host_bus_pkg::lite_data_t reg_rdata_i
);

  logic                     b_pend_q;
  logic                     r_pend_q;
  host_bus_pkg::lite_data_t r_data_q;
  logic                     wr_acc;
  logic                     rd_acc;

  // One outstanding transaction per direction
  assign cfg_aw_ready_o = !b_pend_q;
  assign cfg_w_ready_o  = !b_pend_q;
  assign cfg_ar_ready_o = !r_pend_q;

  // AW and W arrive together
  assign wr_acc = cfg_aw_valid_i && cfg_w_valid_i && !b_pend_q;
  assign rd_acc = cfg_ar_valid_i && !r_pend_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_pend_q <= 1'b0;
    end else if (wr_acc) begin
      b_pend_q <= 1'b1;
    end else if (cfg_b_ready_i) begin
      b_pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_pend_q <= 1'b0;
    end else if (rd_acc) begin
      r_pend_q <= 1'b1;
    end else if (cfg_r_ready_i) begin
      r_pend_q <= 1'b0;
    end
  end

  // Read data held until the master takes it
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      r_data_q <= reg_rdata_i;
    end
  end

  assign reg_wr_o    = wr_acc;
  assign reg_waddr_o = cfg_aw_addr_i;
  assign reg_wdata_o = cfg_w_data_i;
  assign reg_raddr_o = cfg_ar_addr_i;

  assign cfg_b_valid_o = b_pend_q;
  assign cfg_b_resp_o  = host_bus_pkg::RespOkay;
  assign cfg_r_valid_o = r_pend_q;
  assign cfg_r_data_o  = r_data_q;
  assign cfg_r_resp_o  = host_bus_pkg::RespOkay;

endmodule

// ==== design/event_counter_bank.sv ====
`timescale 1ns/1ps

module event_counter_bank #(
  parameter int unsigned CounterWidth = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  host_map_pkg::evt_vec_t   evt_i,
  input  logic                     reg_wr_i,
  input  host_bus_pkg::lite_addr_t reg_waddr_i,
  input  host_bus_pkg::lite_data_t reg_wdata_i,
  input  host_bus_pkg::lite_addr_t reg_raddr_i,
  output host_bus_pkg::lite_data_t reg_rdata_o,
  output logic                     irq_o
);

  typedef logic [CounterWidth-1:0] cnt_t;

  cnt_t                   cnt_q [host_map_pkg::NumEvents];
  cnt_t                   thresh_q;
  host_map_pkg::evt_vec_t irq_status_q;
  host_map_pkg::evt_vec_t cnt_clr;
  host_map_pkg::evt_vec_t thresh_hit;
  host_map_pkg::evt_vec_t status_clr;
  logic                   thresh_wr;
  logic                   status_wr;

  function automatic host_bus_pkg::lite_addr_t cnt_addr(int unsigned idx);
    return host_map_pkg::CntOffset + host_bus_pkg::lite_addr_t'(idx * 4);
  endfunction

  assign thresh_wr  = reg_wr_i && (reg_waddr_i == host_map_pkg::ThreshOffset);
  assign status_wr  = reg_wr_i && (reg_waddr_i == host_map_pkg::IrqStatusOffset);
  assign status_clr = status_wr ? reg_wdata_i[host_map_pkg::NumEvents-1:0] : '0;

  for (genvar k = 0; k < host_map_pkg::NumEvents; k++) begin : gen_cnt
    cnt_t cnt_inc;

    assign cnt_inc    = cnt_q[k] + 1'b1;
    assign cnt_clr[k] = reg_wr_i && (reg_waddr_i == cnt_addr(k));
    // Zero threshold disables the match
    assign thresh_hit[k] = evt_i[k] && !cnt_clr[k] && (thresh_q != '0) &&
                           (cnt_inc == thresh_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[k] <= '0;
      end else if (cnt_clr[k]) begin
        cnt_q[k] <= '0;
      end else if (evt_i[k]) begin
        cnt_q[k] <= cnt_inc;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      thresh_q     <= '0;
      irq_status_q <= '0;
    end else begin
      if (thresh_wr) begin
        thresh_q <= reg_wdata_i[CounterWidth-1:0];
      end
      // A new match beats a clear in the same cycle
      irq_status_q <= (irq_status_q & ~status_clr) | thresh_hit;
    end
  end

  always_comb begin
    reg_rdata_o = host_bus_pkg::CfgFillData;
    for (int unsigned k = 0; k < host_map_pkg::NumEvents; k++) begin
      if (reg_raddr_i == cnt_addr(k)) begin
        reg_rdata_o = host_bus_pkg::lite_data_t'(cnt_q[k]);
      end
    end
    if (reg_raddr_i == host_map_pkg::ThreshOffset) begin
      reg_rdata_o = host_bus_pkg::lite_data_t'(thresh_q);
    end
    if (reg_raddr_i == host_map_pkg::IrqStatusOffset) begin
      reg_rdata_o = host_bus_pkg::lite_data_t'(irq_status_q);
    end
  end

  assign irq_o = |irq_status_q;

endmodule

// ==== design/mem_access_monitor.sv ====
`timescale 1ns/1ps

module mem_access_monitor (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                mem_req_valid_i,
  input  host_bus_pkg::addr_t mem_req_addr_i,
  input  logic                mem_req_we_i,
  output logic [3:0]          mem_evt_o
);

  localparam host_bus_pkg::addr_t HyaxiEnd =
    host_map_pkg::HyaxiBase + host_map_pkg::HyaxiLength;

  logic       hit_dbg;
  logic       hit_hy;
  logic [3:0] evt_d;

  // Both rules are half-open intervals
  assign hit_dbg = (mem_req_addr_i >= host_map_pkg::DebugBase) &&
                   (mem_req_addr_i < host_map_pkg::HyaxiBase);
  assign hit_hy  = (mem_req_addr_i >= host_map_pkg::HyaxiBase) &&
                   (mem_req_addr_i < HyaxiEnd);

  always_comb begin
    evt_d = '0;
    evt_d[host_map_pkg::EvtDbgRead]  = mem_req_valid_i && hit_dbg && !mem_req_we_i;
    evt_d[host_map_pkg::EvtDbgWrite] = mem_req_valid_i && hit_dbg && mem_req_we_i;
    evt_d[host_map_pkg::EvtHyRead]   = mem_req_valid_i && hit_hy && !mem_req_we_i;
    evt_d[host_map_pkg::EvtHyWrite]  = mem_req_valid_i && hit_hy && mem_req_we_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_evt_o <= '0;
    end else begin
      mem_evt_o <= evt_d;
    end
  end

endmodule

// ==== design/dma_evt_sync.sv ====
`timescale 1ns/1ps

module dma_evt_sync (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic valid_o
);

  logic sync1_q;
  logic sync2_q;
  logic sync3_q;
  logic pulse_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      sync3_q <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      sync1_q <= valid_i;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
      // One pulse per rising edge of the synchronized level
      pulse_q <= sync2_q & ~sync3_q;
    end
  end

  // Synchronized level doubles as the handshake ack
  assign ack_o   = sync2_q;
  assign valid_o = pulse_q;

endmodule

// ==== design/host_map_pkg.sv ====
package host_map_pkg;

  // Rule 0 spans debug up to the HyperRAM base
  localparam host_bus_pkg::addr_t DebugBase = 64'h0000_0000_0000_0000;

  // Rule 1 is the HyperRAM window
  localparam host_bus_pkg::addr_t HyaxiBase   = 64'h0000_0000_8000_0000;
  localparam host_bus_pkg::addr_t HyaxiLength = 64'h0000_0000_4000_0000;

  localparam int unsigned NumEvents = 5;

  // Event vector bit positions
  localparam int unsigned EvtDbgRead  = 0;
  localparam int unsigned EvtDbgWrite = 1;
  localparam int unsigned EvtHyRead   = 2;
  localparam int unsigned EvtHyWrite  = 3;
  localparam int unsigned EvtDma      = 4;

  typedef logic [NumEvents-1:0] evt_vec_t;

  // Counter k lives at CntOffset + 4*k
  localparam host_bus_pkg::lite_addr_t CntOffset       = 32'h0000_0000;
  localparam host_bus_pkg::lite_addr_t ThreshOffset    = 32'h0000_0020;
  localparam host_bus_pkg::lite_addr_t IrqStatusOffset = 32'h0000_0024;

endpackage

// ==== design/host_bus_pkg.sv ====
package host_bus_pkg;

  // Memory side address
  localparam int unsigned AddrWidth = 64;

  typedef logic [AddrWidth-1:0] addr_t;

  // AXI-Lite configuration port
  localparam int unsigned LiteAddrWidth = 32;
  localparam int unsigned LiteDataWidth = 32;

  typedef logic [LiteAddrWidth-1:0] lite_addr_t;
  typedef logic [LiteDataWidth-1:0] lite_data_t;

  typedef logic [1:0] resp_t;

  localparam resp_t RespOkay = 2'b00;

  // Returned for reads that hit no register
  localparam lite_data_t CfgFillData = 32'hdeadf000;

endpackage
